//--- csr_pkg.sv
package csr_pkg;

    // register width of the core
    localparam int unsigned XLEN = 64;

    typedef logic [11:0] csr_addr_t;

    // machine CSR indices
    localparam csr_addr_t CSR_MCYCLE   = 12'hb00;
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MIP      = 12'h344;

    // mstatus field positions
    localparam int unsigned MSTATUS_MIE    = 3;
    localparam int unsigned MSTATUS_MPIE   = 7;
    localparam int unsigned MSTATUS_MPP_LO = 11;
    localparam int unsigned MSTATUS_FS_LO  = 13;
    localparam int unsigned MSTATUS_SD     = 63;

    // timer enable and pending bits in mie / mip
    localparam int unsigned MIE_MTIE = 7;
    localparam int unsigned MIP_MTIP = 7;

    // trap causes
    localparam logic [XLEN-1:0] MCAUSE_ECALL_M = 64'd11;
    localparam logic [XLEN-1:0] MCAUSE_MTIMER  = {1'b1, {(XLEN-4){1'b0}}, 3'd7};

    // clint register selects
    localparam logic TMR_ADDR_MTIME    = 1'b0;
    localparam logic TMR_ADDR_MTIMECMP = 1'b1;

    typedef enum logic [1:0] {
        SEQ_IDLE       = 2'd0,
        SEQ_TRAP_REDIR = 2'd1,
        SEQ_RET_REDIR  = 2'd2
    } seq_state_t;

endpackage

//--- clint_timer.sv
`timescale 1ns/1ns

module clint_timer #(
    parameter int unsigned TICK_DIV = 4
) (
    input  logic                     clk,
    input  logic                     wr_mscrstch,
    input  logic                     tmr_wr_en,
    input  logic                     tmr_addr,
    input  logic [csr_pkg::XLEN-1:0] tmr_wdata,
    output logic [csr_pkg::XLEN-1:0] tmr_rdata,
    output logic                     mtip
);
    import csr_pkg::*;

    // at least one bit so a divide by one still builds
    localparam int unsigned PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PW-1:0]   presc;
    logic            tick;
    logic [XLEN-1:0] mtime;
    logic [XLEN-1:0] mtimecmp;

    assign tick = (presc == PW'(TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // software write wins over the tick
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtime <= '0;
        end else if (tmr_wr_en && tmr_addr == TMR_ADDR_MTIME) begin
            mtime <= tmr_wdata;
        end else if (tick) begin
            mtime <= mtime + 1'b1;
        end
    end

    // all ones keeps the interrupt quiet until software arms it
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtimecmp <= '1;
        end else if (tmr_wr_en && tmr_addr == TMR_ADDR_MTIMECMP) begin
            mtimecmp <= tmr_wdata;
        end
    end

    assign tmr_rdata = (tmr_addr == TMR_ADDR_MTIMECMP) ? mtimecmp : mtime;

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtip <= 1'b0;
        end else begin
            mtip <= (mtime >= mtimecmp);
        end
    end

endmodule

//--- machine_csr.sv
`timescale 1ns/1ns

module machine_csr (
    input  logic                     clk,
    input  logic                     wr_mscrstch,
    input  logic [csr_pkg::XLEN-1:0] pc_i,
    input  logic                     csr_rd_en,
    input  logic                     csr_wr_en,
    input  csr_pkg::csr_addr_t       csr_idx,
    input  logic                     cmt_mret_ena,
    input  logic                     ecall_trap_ena,
    input  logic [csr_pkg::XLEN-1:0] trap_mcause_value,
    input  logic                     tmr_intr_ena,
    output logic                     tmr_trap_ena,
    output logic [csr_pkg::XLEN-1:0] read_csr_data,
    input  logic [csr_pkg::XLEN-1:0] wbck_csr_data,
    input  logic                     ex_stall
);
    import csr_pkg::*;

    logic            trap_enter;
    logic [XLEN-1:0] mcycle;
    logic            mstatus_mie;
    logic            mstatus_mpie;
    logic [1:0]      mstatus_mpp;
    logic [1:0]      mstatus_fs;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:2] mtvec_base;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic            mie_mtie;
    logic [XLEN-1:0] mie;
    logic            mip_mtip;
    logic [XLEN-1:0] mip;
    logic [XLEN-1:0] mscratch;

    // address decode
    wire mcycle_sel   = (csr_idx == CSR_MCYCLE);
    wire mstatus_sel  = (csr_idx == CSR_MSTATUS);
    wire mtvec_sel    = (csr_idx == CSR_MTVEC);
    wire mepc_sel     = (csr_idx == CSR_MEPC);
    wire mcause_sel   = (csr_idx == CSR_MCAUSE);
    wire mie_sel      = (csr_idx == CSR_MIE);
    wire mip_sel      = (csr_idx == CSR_MIP);
    wire mscratch_sel = (csr_idx == CSR_MSCRATCH);

    wire mcycle_wr   = csr_wr_en && mcycle_sel;
    wire mstatus_wr  = csr_wr_en && mstatus_sel;
    wire mtvec_wr    = csr_wr_en && mtvec_sel;
    wire mcause_wr   = csr_wr_en && mcause_sel;
    wire mie_wr      = csr_wr_en && mie_sel;
    wire mscratch_wr = csr_wr_en && mscratch_sel;

    // a timer trap only lands while the core is not stalled
    assign trap_enter = ecall_trap_ena | (tmr_trap_ena & ~ex_stall);

    // trap entry forces mtvec onto the read port, mret forces mepc
    wire mcycle_rd   = csr_rd_en && mcycle_sel;
    wire mstatus_rd  = csr_rd_en && mstatus_sel;
    wire mtvec_rd    = (csr_rd_en && mtvec_sel) | trap_enter;
    wire mepc_rd     = (csr_rd_en && mepc_sel) | cmt_mret_ena;
    wire mcause_rd   = csr_rd_en && mcause_sel;
    wire mie_rd      = csr_rd_en && mie_sel;
    wire mip_rd      = csr_rd_en && mip_sel;
    wire mscratch_rd = csr_rd_en && mscratch_sel;

    // free running cycle counter
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mcycle <= '0;
        end else if (mcycle_wr) begin
            mcycle <= wbck_csr_data;
        end else begin
            mcycle <= mcycle + 1'b1;
        end
    end

    // mstatus interrupt stack
    wire mstatus_ena = mstatus_wr | cmt_mret_ena | trap_enter;

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
        end else if (mstatus_ena && !ex_stall) begin
            if (trap_enter) begin
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end else if (cmt_mret_ena) begin
                mstatus_mpie <= 1'b1;
                mstatus_mie  <= mstatus_mpie;
            end else begin
                mstatus_mpie <= wbck_csr_data[MSTATUS_MPIE];
                mstatus_mie  <= wbck_csr_data[MSTATUS_MIE];
            end
        end
    end

    // previous privilege is not held back by the stall
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mstatus_mpp <= 2'b00;
        end else if (trap_enter) begin
            mstatus_mpp <= 2'b11;
        end else if (cmt_mret_ena) begin
            mstatus_mpp <= 2'b00;
        end else if (mstatus_wr) begin
            mstatus_mpp <= wbck_csr_data[MSTATUS_MPP_LO +: 2];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mstatus_fs <= 2'b00;
        end else if (mstatus_wr) begin
            mstatus_fs <= wbck_csr_data[MSTATUS_FS_LO +: 2];
        end
    end

    always_comb begin
        mstatus                      = '0;
        mstatus[MSTATUS_SD]          = (mstatus_fs == 2'b11);
        mstatus[MSTATUS_FS_LO +: 2]  = mstatus_fs;
        mstatus[MSTATUS_MPP_LO +: 2] = mstatus_mpp;
        mstatus[MSTATUS_MPIE]        = mstatus_mpie;
        mstatus[MSTATUS_MIE]         = mstatus_mie;
    end

    // direct mode only
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtvec_base <= '0;
        end else if (mtvec_wr) begin
            mtvec_base <= wbck_csr_data[XLEN-1:2];
        end
    end

    assign mtvec = {mtvec_base, 2'b00};

    // trap entry stores the pc through the write-back path
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mepc <= '0;
        end else if ((csr_wr_en && mepc_sel) || trap_enter) begin
            mepc <= {wbck_csr_data[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mcause <= '0;
        end else if (trap_enter) begin
            mcause <= trap_mcause_value;
        end else if (mcause_wr) begin
            mcause <= wbck_csr_data;
        end
    end

    // only the timer enable is implemented
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mie_mtie <= 1'b0;
        end else if (mie_wr) begin
            mie_mtie <= wbck_csr_data[MIE_MTIE];
        end
    end

    always_comb begin
        mie           = '0;
        mie[MIE_MTIE] = mie_mtie;
    end

    // pending bit tracks the timer level and ignores software writes
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mip_mtip <= 1'b0;
        end else begin
            mip_mtip <= tmr_intr_ena;
        end
    end

    always_comb begin
        mip           = '0;
        mip[MIP_MTIP] = mip_mtip;
    end

    assign tmr_trap_ena = mip_mtip & mstatus_mie & mie_mtie & (pc_i != '0);

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mscratch <= '0;
        end else if (mscratch_wr) begin
            mscratch <= wbck_csr_data;
        end
    end

    assign read_csr_data = ({XLEN{mcycle_rd}}   & mcycle)
                         | ({XLEN{mstatus_rd}}  & mstatus)
                         | ({XLEN{mtvec_rd}}    & mtvec)
                         | ({XLEN{mepc_rd}}     & mepc)
                         | ({XLEN{mcause_rd}}   & mcause)
                         | ({XLEN{mie_rd}}      & mie)
                         | ({XLEN{mip_rd}}      & mip)
                         | ({XLEN{mscratch_rd}} & mscratch);

endmodule

//--- trap_sequencer.sv
`timescale 1ns/1ns

module trap_sequencer (
    input  logic                     clk,
    input  logic                     wr_mscrstch,
    input  logic                     ex_stall,
    input  logic                     ecall_req,
    input  logic                     mret_req,
    input  logic                     tmr_trap_ena,
    input  logic [csr_pkg::XLEN-1:0] pc,
    input  logic [csr_pkg::XLEN-1:0] csr_wdata,
    input  logic [csr_pkg::XLEN-1:0] read_csr_data,
    output logic                     ecall_trap_ena,
    output logic                     cmt_mret_ena,
    output logic [csr_pkg::XLEN-1:0] trap_mcause_value,
    output logic [csr_pkg::XLEN-1:0] wbck_csr_data,
    output logic                     redirect_valid,
    output logic [csr_pkg::XLEN-1:0] redirect_pc
);
    import csr_pkg::*;

    seq_state_t state;
    seq_state_t state_nxt;
    logic       can_take;
    logic       tmr_take;
    logic       take_any;

    // requests only land in idle with the pipe moving
    assign can_take = (state == SEQ_IDLE) && !ex_stall;

    // timer beats ecall, ecall beats mret
    assign tmr_take       = can_take && tmr_trap_ena;
    assign ecall_trap_ena = can_take && !tmr_trap_ena && ecall_req;
    assign cmt_mret_ena   = can_take && !tmr_trap_ena && !ecall_req && mret_req;
    assign take_any       = tmr_take | ecall_trap_ena | cmt_mret_ena;

    assign trap_mcause_value = tmr_trap_ena ? MCAUSE_MTIMER : MCAUSE_ECALL_M;

    // trapping pc goes into mepc over the normal write path
    assign wbck_csr_data = (ecall_trap_ena || tmr_trap_ena) ? pc : csr_wdata;

    always_comb begin
        state_nxt = SEQ_IDLE;
        case (state)
            SEQ_IDLE: begin
                if (tmr_take || ecall_trap_ena) begin
                    state_nxt = SEQ_TRAP_REDIR;
                end else if (cmt_mret_ena) begin
                    state_nxt = SEQ_RET_REDIR;
                end
            end
            default: begin
                state_nxt = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // csr file presents mtvec or mepc in the accepting cycle
    always_ff @(posedge clk) begin
        if (take_any) begin
            redirect_pc <= read_csr_data;
        end
    end

    assign redirect_valid = (state == SEQ_TRAP_REDIR) || (state == SEQ_RET_REDIR);

endmodule

//--- trap_unit_top.sv
`timescale 1ns/1ns

module trap_unit_top #(
    parameter int unsigned TICK_DIV = 4
) (
    input  logic                     clk,
    input  logic                     wr_mscrstch,
    input  logic [csr_pkg::XLEN-1:0] pc,
    input  logic                     csr_rd_en,
    input  logic                     csr_wr_en,
    input  csr_pkg::csr_addr_t       csr_idx,
    input  logic [csr_pkg::XLEN-1:0] csr_wdata,
    input  logic                     ecall_req,
    input  logic                     mret_req,
    input  logic                     ex_stall,
    input  logic                     tmr_wr_en,
    input  logic                     tmr_addr,
    input  logic [csr_pkg::XLEN-1:0] tmr_wdata,
    output logic [csr_pkg::XLEN-1:0] csr_rdata,
    output logic                     redirect_valid,
    output logic [csr_pkg::XLEN-1:0] redirect_pc,
    output logic [csr_pkg::XLEN-1:0] tmr_rdata
);
    import csr_pkg::*;

    logic            mtip;
    logic            tmr_trap_ena;
    logic            ecall_trap_ena;
    logic            cmt_mret_ena;
    logic [XLEN-1:0] read_csr_data;
    logic [XLEN-1:0] trap_mcause_value;
    logic [XLEN-1:0] wbck_csr_data;

    assign csr_rdata = read_csr_data;

    clint_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_timer (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .tmr_wr_en   (tmr_wr_en),
        .tmr_addr    (tmr_addr),
        .tmr_wdata   (tmr_wdata),
        .tmr_rdata   (tmr_rdata),
        .mtip        (mtip)
    );

    machine_csr u_csr (
        .clk               (clk),
        .wr_mscrstch       (wr_mscrstch),
        .pc_i              (pc),
        .csr_rd_en         (csr_rd_en),
        .csr_wr_en         (csr_wr_en),
        .csr_idx           (csr_idx),
        .cmt_mret_ena      (cmt_mret_ena),
        .ecall_trap_ena    (ecall_trap_ena),
        .trap_mcause_value (trap_mcause_value),
        .tmr_intr_ena      (mtip),
        .tmr_trap_ena      (tmr_trap_ena),
        .read_csr_data     (read_csr_data),
        .wbck_csr_data     (wbck_csr_data),
        .ex_stall          (ex_stall)
    );

    trap_sequencer u_seq (
        .clk               (clk),
        .wr_mscrstch       (wr_mscrstch),
        .ex_stall          (ex_stall),
        .ecall_req         (ecall_req),
        .mret_req          (mret_req),
        .tmr_trap_ena      (tmr_trap_ena),
        .pc                (pc),
        .csr_wdata         (csr_wdata),
        .read_csr_data     (read_csr_data),
        .ecall_trap_ena    (ecall_trap_ena),
        .cmt_mret_ena      (cmt_mret_ena),
        .trap_mcause_value (trap_mcause_value),
        .wbck_csr_data     (wbck_csr_data),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

endmodule

//--- tb_trap_unit.sv
`timescale 1ns/1ns

module tb_trap_unit;
    import csr_pkg::*;

    localparam int unsigned TICK_DIV   = 4;
    localparam int          MAX_CYCLES = 3000;
    localparam int          ROUNDS     = 16;

    logic            clk = 1'b0;
    logic            wr_mscrstch;
    logic [XLEN-1:0] pc;
    logic            csr_rd_en;
    logic            csr_wr_en;
    csr_addr_t       csr_idx;
    logic [XLEN-1:0] csr_wdata;
    logic            ecall_req;
    logic            mret_req;
    logic            ex_stall;
    logic            tmr_wr_en;
    logic            tmr_addr;
    logic [XLEN-1:0] tmr_wdata;
    logic [XLEN-1:0] csr_rdata;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    logic [XLEN-1:0] tmr_rdata;

    // expected CSR state
    logic [XLEN-1:0] exp_mtvec;
    logic [XLEN-1:0] exp_mepc;
    logic [XLEN-1:0] exp_mcause;
    logic [XLEN-1:0] exp_mscratch;
    logic            exp_mtie;
    logic            exp_mie;
    logic            exp_mpie;
    logic [1:0]      exp_mpp;
    logic [1:0]      exp_fs;

    logic [31:0]     lfsr = 32'h4cd2_16bf;
    logic [XLEN-1:0] last_mtime = '0;
    int              cycles = 0;

    trap_unit_top #(.TICK_DIV(TICK_DIV)) dut (.*);

    always #2 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                                   input logic [XLEN-1:0] got);
        stop_run($sformatf("[ERROR] %s expected %h got %h", name, exp, got));
    endtask

    // galois lfsr stepped once per bit
    function automatic logic [XLEN-1:0] rand_bits(input int n);
        logic [XLEN-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[XLEN-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] mstatus_word();
        logic [XLEN-1:0] w;
        w = '0;
        w[MSTATUS_SD] = (exp_fs == 2'b11);
        w[MSTATUS_FS_LO +: 2] = exp_fs;
        w[MSTATUS_MPP_LO +: 2] = exp_mpp;
        w[MSTATUS_MPIE] = exp_mpie;
        w[MSTATUS_MIE] = exp_mie;
        return w;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic read_csr(input csr_addr_t idx, output logic [XLEN-1:0] val);
        csr_rd_en = 1'b1;
        csr_idx   = idx;
        #1;
        val = csr_rdata;
        tick();
        csr_rd_en = 1'b0;
    endtask

    task automatic check_csr(input string name, input csr_addr_t idx,
                             input logic [XLEN-1:0] exp);
        logic [XLEN-1:0] got;
        read_csr(idx, got);
        assert (got === exp) else report_mismatch(name, exp, got);
    endtask

    task automatic write_csr(input csr_addr_t idx, input logic [XLEN-1:0] data);
        csr_wr_en = 1'b1;
        csr_idx   = idx;
        csr_wdata = data;
        tick();
        csr_wr_en = 1'b0;
    endtask

    // the request is already driven and the redirect lands one cycle later
    task automatic expect_redirect(input logic [XLEN-1:0] target);
        #1;
        assert (redirect_valid === 1'b0)
            else report_mismatch("redirect_valid", 64'h0, 64'(redirect_valid));
        tick();
        ecall_req = 1'b0;
        mret_req  = 1'b0;
        #1;
        assert (redirect_valid === 1'b1)
            else report_mismatch("redirect_valid", 64'h1, 64'(redirect_valid));
        assert (redirect_pc === target) else report_mismatch("redirect_pc", target, redirect_pc);
        tick();
    endtask

    task automatic enter_trap_model(input logic [XLEN-1:0] trap_pc,
                                    input logic [XLEN-1:0] cause);
        exp_mepc   = {trap_pc[XLEN-1:2], 2'b00};
        exp_mcause = cause;
        exp_mpie   = exp_mie;
        exp_mie    = 1'b0;
        exp_mpp    = 2'b11;
    endtask

    task automatic check_trap_csrs();
        check_csr("mepc", CSR_MEPC, exp_mepc);
        check_csr("mcause", CSR_MCAUSE, exp_mcause);
        check_csr("mstatus", CSR_MSTATUS, mstatus_word());
    endtask

    task automatic take_ecall(input logic [XLEN-1:0] trap_pc);
        pc        = trap_pc;
        ecall_req = 1'b1;
        expect_redirect(exp_mtvec);
        enter_trap_model(trap_pc, MCAUSE_ECALL_M);
        check_trap_csrs();
    endtask

    task automatic take_mret();
        mret_req = 1'b1;
        expect_redirect(exp_mepc);
        exp_mie  = exp_mpie;
        exp_mpie = 1'b1;
        exp_mpp  = 2'b00;
        check_csr("mstatus", CSR_MSTATUS, mstatus_word());
    endtask

    task automatic no_redirect_for(input int n);
        repeat (n) begin
            #1;
            assert (redirect_valid === 1'b0)
                else report_mismatch("redirect_valid", 64'h0, 64'(redirect_valid));
            tick();
        end
    endtask

    assert property (@(posedge clk) disable iff (wr_mscrstch) redirect_valid |=> !redirect_valid)
        else report_mismatch("redirect_valid", 64'h0, 64'h1);

    // mtime must never go backwards
    always @(negedge clk) begin
        if (!wr_mscrstch && !tmr_wr_en && tmr_addr == TMR_ADDR_MTIME) begin
            assert (tmr_rdata >= last_mtime) else report_mismatch("mtime", last_mtime, tmr_rdata);
            last_mtime <= tmr_rdata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_run($sformatf("timeout after %0d cycles with the sequencer in state %0d",
                               cycles, dut.u_seq.state));
        end
    end

    initial begin
        logic [XLEN-1:0] v1;
        logic [XLEN-1:0] v2;
        logic [XLEN-1:0] w;
        logic [XLEN-1:0] cmp;
        logic [XLEN-1:0] keep_mepc;
        int              gap;
        int              waited;
        bit              seen;
        wr_mscrstch = 1'b1;
        pc          = 64'h100;
        csr_rd_en   = 1'b0;
        csr_wr_en   = 1'b0;
        csr_idx     = CSR_MSCRATCH;
        csr_wdata   = '0;
        ecall_req   = 1'b0;
        mret_req    = 1'b0;
        ex_stall    = 1'b0;
        tmr_wr_en   = 1'b0;
        tmr_addr    = TMR_ADDR_MTIME;
        tmr_wdata   = '0;
        exp_mtvec    = '0;
        exp_mepc     = '0;
        exp_mcause   = '0;
        exp_mscratch = '0;
        exp_mtie     = 1'b0;
        exp_mie      = 1'b0;
        exp_mpie     = 1'b0;
        exp_mpp      = 2'b00;
        exp_fs       = 2'b00;
        repeat (16) @(posedge clk);
        #1;
        wr_mscrstch = 1'b0;
        check_trap_csrs();

        // random CSR writes and masked readback
        for (int i = 0; i < ROUNDS; i++) begin
            w = rand_bits(64);
            write_csr(CSR_MSCRATCH, w);
            exp_mscratch = w;
            w = rand_bits(64);
            write_csr(CSR_MTVEC, w);
            exp_mtvec = {w[XLEN-1:2], 2'b00};
            w = rand_bits(64);
            write_csr(CSR_MEPC, w);
            exp_mepc = {w[XLEN-1:2], 2'b00};
            w = rand_bits(64);
            write_csr(CSR_MCAUSE, w);
            exp_mcause = w;
            w = rand_bits(64);
            write_csr(CSR_MIE, w);
            exp_mtie = w[MIE_MTIE];
            w = rand_bits(64);
            write_csr(CSR_MSTATUS, w);
            exp_mie  = w[MSTATUS_MIE];
            exp_mpie = w[MSTATUS_MPIE];
            exp_mpp  = w[MSTATUS_MPP_LO +: 2];
            exp_fs   = w[MSTATUS_FS_LO +: 2];
            write_csr(CSR_MIP, rand_bits(64));
            check_csr("mscratch", CSR_MSCRATCH, exp_mscratch);
            check_csr("mtvec", CSR_MTVEC, exp_mtvec);
            check_csr("mie", CSR_MIE, 64'(exp_mtie) << MIE_MTIE);
            check_csr("mip", CSR_MIP, 64'h0);
            check_trap_csrs();
        end

        // mcycle counts every clock and restarts from a write
        read_csr(CSR_MCYCLE, v1);
        gap = int'(rand_bits(4)) + 2;
        repeat (gap) tick();
        read_csr(CSR_MCYCLE, v2);
        assert (v2 === v1 + 64'(gap + 1)) else report_mismatch("mcycle", v1 + 64'(gap + 1), v2);
        w = rand_bits(64);
        write_csr(CSR_MCYCLE, w);
        check_csr("mcycle", CSR_MCYCLE, w);
        repeat (gap) tick();
        check_csr("mcycle", CSR_MCYCLE, w + 64'(gap + 1));

        // ecall and mret with interrupts on and FS dirty so SD reads 1
        w = rand_bits(64);
        write_csr(CSR_MTVEC, w);
        exp_mtvec = {w[XLEN-1:2], 2'b00};
        write_csr(CSR_MSTATUS, (64'h1 << MSTATUS_MIE) | (64'h3 << MSTATUS_FS_LO));
        exp_mie  = 1'b1;
        exp_mpie = 1'b0;
        exp_mpp  = 2'b00;
        exp_fs   = 2'b11;
        check_csr("mstatus", CSR_MSTATUS, mstatus_word());
        take_ecall(rand_bits(64) | 64'h100);
        take_mret();

        // a stalled ecall is dropped and then repeated
        keep_mepc = exp_mepc;
        pc        = rand_bits(64) | 64'h100;
        ex_stall  = 1'b1;
        ecall_req = 1'b1;
        no_redirect_for(4);
        ex_stall  = 1'b0;
        ecall_req = 1'b0;
        no_redirect_for(1);
        check_csr("mepc", CSR_MEPC, keep_mepc);
        take_ecall(pc);
        take_mret();

        // arm mtimecmp some ticks ahead
        #1;
        cmp = tmr_rdata + 64'd48 + rand_bits(4);
        tick();
        tmr_wr_en = 1'b1;
        tmr_addr  = TMR_ADDR_MTIMECMP;
        tmr_wdata = cmp;
        tick();
        tmr_wr_en = 1'b0;
        #1;
        assert (tmr_rdata === cmp) else report_mismatch("mtimecmp", cmp, tmr_rdata);
        tick();
        tmr_addr = TMR_ADDR_MTIME;
        write_csr(CSR_MIE, 64'h1 << MIE_MTIE);
        exp_mtie = 1'b1;

        // two register stages plus a tick of slack
        seen   = 1'b0;
        waited = 0;
        while (!seen) begin
            #1;
            if (tmr_rdata < cmp) begin
                assert (redirect_valid === 1'b0)
                    else report_mismatch("redirect_valid", 64'h0, 64'(redirect_valid));
            end else if (redirect_valid === 1'b1) begin
                seen = 1'b1;
            end else if (waited >= 2 * TICK_DIV + 4) begin
                stop_run("timer interrupt was not taken in time after mtime reached mtimecmp");
            end else begin
                waited++;
            end
            if (!seen) begin
                tick();
            end
        end
        assert (redirect_pc === exp_mtvec)
            else report_mismatch("redirect_pc", exp_mtvec, redirect_pc);
        enter_trap_model(pc, MCAUSE_MTIMER);
        tick();
        check_trap_csrs();
        check_csr("mip", CSR_MIP, 64'h1 << MIP_MTIP);
        no_redirect_for(20);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- all.f
csr_pkg.sv
clint_timer.sv
machine_csr.sv
trap_sequencer.sv
trap_unit_top.sv
tb_trap_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run tb_trap_unit with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_trap_unit \
    -f all.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0
